// File: hw/pic_pkg.sv
package pic_pkg;

	// ==================================================================
	// sizes and basic types
	// ==================================================================

	// 32 sources, source 0 is the nmi line
	localparam int NUM_SRC = 32;

	typedef logic [NUM_SRC-1:0] pic_src_t;
	// source number, zero means no request
	typedef logic [4:0] pic_id_t;
	typedef logic [7:0] pic_cause_t;
	typedef logic [3:0] pic_level_t;
	typedef logic [5:0] pic_core_t;

	typedef logic [7:0]  axil_addr_t;
	typedef logic [31:0] axil_data_t;

	// every response on the register port is okay
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	// ==================================================================
	// register map
	// ==================================================================

	localparam axil_addr_t REG_CAUSE    = 8'h00;
	localparam axil_addr_t REG_IE       = 8'h04;
	localparam axil_addr_t REG_IE_CLR   = 8'h08;
	localparam axil_addr_t REG_IE_SET   = 8'h0C;
	localparam axil_addr_t REG_ES       = 8'h10;
	localparam axil_addr_t REG_EDGE_RST = 8'h14;
	localparam axil_addr_t REG_TRIG     = 8'h18;
	// control word of source n at REG_SRC_BASE + 4n
	localparam axil_addr_t REG_SRC_BASE = 8'h80;

	// bit positions inside a control word
	localparam int CTL_CAUSE_LSB = 0;
	localparam int CTL_LEVEL_LSB = 8;
	localparam int CTL_IE_BIT    = 16;
	localparam int CTL_ES_BIT    = 17;
	localparam int CTL_CORE_LSB  = 24;

	// reset values
	localparam pic_level_t RST_LEVEL = 4'd8;
	localparam pic_src_t   RST_ES    = '1;
	localparam pic_src_t   RST_IE    = '0;

	// sources that take part in encoding, nmi excluded
	localparam pic_src_t ENC_MASK = 32'hFFFF_FFFE;

	// per-source settings held by the register block
	typedef struct packed {
		pic_cause_t cause;
		pic_level_t level;
		pic_core_t  core;
	} pic_src_cfg_t;

	// request presented to the processor
	typedef struct packed {
		pic_level_t level;
		pic_cause_t cause;
		pic_core_t  core;
	} pic_irq_t;

endpackage

// File: hw/pic_axil_regs.sv
`timescale 1ns/1ns

module pic_axil_regs import pic_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_i,
	// axi4-lite write address / data / response
	input  axil_addr_t                  s_awaddr_i,
	input  logic                        s_awvalid_i,
	output logic                        s_awready_o,
	input  axil_data_t                  s_wdata_i,
	// strobes are ignored, every write is a full word
	input  logic [3:0]                  s_wstrb_i,
	input  logic                        s_wvalid_i,
	output logic                        s_wready_o,
	output logic [1:0]                  s_bresp_o,
	output logic                        s_bvalid_o,
	input  logic                        s_bready_i,
	// axi4-lite read address / data
	input  axil_addr_t                  s_araddr_i,
	input  logic                        s_arvalid_i,
	output logic                        s_arready_o,
	output axil_data_t                  s_rdata_o,
	output logic [1:0]                  s_rresp_o,
	output logic                        s_rvalid_o,
	input  logic                        s_rready_i,
	// current winner from the encoder
	input  pic_id_t                     cur_id_i,
	// controls toward the sense block and encoder
	output pic_src_t                    ie_o,
	output pic_src_t                    es_o,
	output pic_src_t                    edge_rst_o,
	output pic_src_t                    trig_o,
	output pic_src_cfg_t [NUM_SRC-1:0]  src_cfg_o
);

	// control state
	pic_src_t                   ie_q;
	pic_src_t                   es_q;
	pic_src_t                   edge_rst_q;
	pic_src_t                   trig_q;
	pic_src_cfg_t [NUM_SRC-1:0] cfg_q;

	// bus channel state
	logic       bvalid_q;
	logic       rvalid_q;
	axil_data_t rdata_q;

	// decode helpers
	logic       wr_accept;
	logic       rd_accept;
	axil_addr_t wr_addr;
	axil_addr_t rd_addr;
	pic_id_t    wr_src;
	pic_id_t    rd_src;
	pic_id_t    wr_sel;
	axil_data_t rd_word;

	// ==================================================================
	// handshakes
	// ==================================================================

	// write taken when both channels are valid and no response pending
	assign wr_accept   = s_awvalid_i & s_wvalid_i & ~bvalid_q;
	assign s_awready_o = wr_accept;
	assign s_wready_o  = wr_accept;

	// one read in flight at a time
	assign s_arready_o = ~rvalid_q;
	assign rd_accept   = s_arvalid_i & ~rvalid_q;

	assign s_bvalid_o = bvalid_q;
	assign s_bresp_o  = AXI_RESP_OKAY;
	assign s_rvalid_o = rvalid_q;
	assign s_rdata_o  = rdata_q;
	assign s_rresp_o  = AXI_RESP_OKAY;

	// word-aligned offsets, low two bits dropped
	assign wr_addr = {s_awaddr_i[7:2], 2'b00};
	assign rd_addr = {s_araddr_i[7:2], 2'b00};
	// source index of a control-word access
	assign wr_src  = s_awaddr_i[6:2];
	assign rd_src  = s_araddr_i[6:2];
	// bit selected by the single-bit registers
	assign wr_sel  = s_wdata_i[4:0];

	always_ff @(posedge clk)
	begin
		if (rst_i)
			bvalid_q <= 1'b0;
		else if (wr_accept)
			bvalid_q <= 1'b1;
		else if (s_bready_i)
			bvalid_q <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			rvalid_q <= 1'b0;
		else if (rd_accept)
			rvalid_q <= 1'b1;
		else if (s_rready_i)
			rvalid_q <= 1'b0;
	end

	// ==================================================================
	// register writes
	// ==================================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			ie_q       <= RST_IE;
			es_q       <= RST_ES;
			edge_rst_q <= '0;
			trig_q     <= '0;
			for (int n = 0; n < NUM_SRC; n++)
			begin
				cfg_q[n].cause <= '0;
				cfg_q[n].level <= RST_LEVEL;
				cfg_q[n].core  <= '0;
			end
		end
		else
		begin
			// pulses live for a single cycle
			edge_rst_q <= '0;
			trig_q     <= '0;
			if (wr_accept)
			begin
				case (wr_addr)
					// cause register is read only
					REG_CAUSE:    ;
					REG_IE:       ie_q <= s_wdata_i;
					REG_IE_CLR:   ie_q[wr_sel] <= 1'b0;
					REG_IE_SET:   ie_q[wr_sel] <= 1'b1;
					REG_ES:       es_q <= s_wdata_i;
					REG_EDGE_RST: edge_rst_q[wr_sel] <= 1'b1;
					REG_TRIG:     trig_q[wr_sel] <= 1'b1;
					default:
					begin
						// per-source control word, also carries its ie and es bits
						if (wr_addr >= REG_SRC_BASE)
						begin
							cfg_q[wr_src].cause <= s_wdata_i[CTL_CAUSE_LSB +: $bits(pic_cause_t)];
							cfg_q[wr_src].level <= s_wdata_i[CTL_LEVEL_LSB +: $bits(pic_level_t)];
							cfg_q[wr_src].core  <= s_wdata_i[CTL_CORE_LSB +: $bits(pic_core_t)];
							ie_q[wr_src]        <= s_wdata_i[CTL_IE_BIT];
							es_q[wr_src]        <= s_wdata_i[CTL_ES_BIT];
						end
					end
				endcase
			end
		end
	end

	// ==================================================================
	// register reads
	// ==================================================================

	always_comb
	begin
		rd_word = '0;
		if (rd_addr >= REG_SRC_BASE)
		begin
			// control word readback
			rd_word[CTL_CAUSE_LSB +: $bits(pic_cause_t)] = cfg_q[rd_src].cause;
			rd_word[CTL_LEVEL_LSB +: $bits(pic_level_t)] = cfg_q[rd_src].level;
			rd_word[CTL_CORE_LSB +: $bits(pic_core_t)]   = cfg_q[rd_src].core;
			rd_word[CTL_IE_BIT]                          = ie_q[rd_src];
			rd_word[CTL_ES_BIT]                          = es_q[rd_src];
		end
		else if (rd_addr == REG_CAUSE)
			rd_word[CTL_CAUSE_LSB +: $bits(pic_cause_t)] = cfg_q[cur_id_i].cause;
		else
			// everything else, REG_ES included, reads the enable mask
			rd_word = ie_q;
	end

	// read data captured on acceptance, held until taken
	always_ff @(posedge clk)
	begin
		if (rd_accept)
			rdata_q <= rd_word;
	end

	assign ie_o       = ie_q;
	assign es_o       = es_q;
	assign edge_rst_o = edge_rst_q;
	assign trig_o     = trig_q;
	assign src_cfg_o  = cfg_q;

	// response channels hold until the manager takes them
	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o);

	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst_i)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o));

endmodule

// File: hw/pic_source_sense.sv
`timescale 1ns/1ns

module pic_source_sense import pic_pkg::*;
(
	input  logic     clk,
	input  logic     rst_i,
	// raw request lines, assumed synchronous to clk
	input  pic_src_t irq_i,
	// 1 = edge sensitive, 0 = level sensitive
	input  pic_src_t es_i,
	// single-cycle pulses from the register block
	input  pic_src_t edge_rst_i,
	input  pic_src_t trig_i,
	output pic_src_t pending_o
);

	// delayed copy of the inputs for rising-edge detection
	pic_src_t irq_d_q;
	// edge latches
	pic_src_t latch_q;
	pic_src_t rise;

	// ==================================================================
	// edge detection
	// ==================================================================

	always_ff @(posedge clk)
	begin
		irq_d_q <= irq_i;
	end

	assign rise = irq_i & ~irq_d_q;

	// set on a rising input or a trigger
	// edge reset wins over a set in the same cycle
	always_ff @(posedge clk)
	begin
		if (rst_i)
			latch_q <= '0;
		else
			latch_q <= (latch_q | rise | trig_i) & ~edge_rst_i;
	end

	// ==================================================================
	// pending selection
	// ==================================================================

	// edge sources show their latch, level sources the raw line
	// nmi never reaches the encoder
	assign pending_o = ((es_i & latch_q) | (~es_i & irq_i)) & ENC_MASK;

endmodule

// File: hw/pic_prio_encoder.sv
`timescale 1ns/1ns

module pic_prio_encoder import pic_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_i,
	input  pic_src_t                    pending_i,
	input  pic_src_t                    ie_i,
	input  pic_src_cfg_t [NUM_SRC-1:0]  src_cfg_i,
	// the nmi request line itself
	input  logic                        nmi_i,
	// registered winner, zero when idle
	output pic_id_t                     cur_id_o,
	output pic_irq_t                    irq_o,
	output logic                        nmi_o
);

	// enabled requests
	pic_src_t     req;
	pic_id_t      win_id;
	pic_id_t      cur_id_q;
	pic_src_cfg_t sel_cfg;
	pic_irq_t     irq_q;
	logic         nmi_q;

	// ==================================================================
	// priority encode
	// ==================================================================

	// mask applied here so a disabled source cannot shadow a later one
	assign req = pending_i & ie_i;

	// lowest number wins, so scan downward and let the last hit stand
	always_comb
	begin
		win_id = '0;
		for (int n = NUM_SRC - 1; n > 0; n--)
		begin
			if (req[n])
				win_id = pic_id_t'(n);
		end
	end

	// settings of the registered winner
	assign sel_cfg = src_cfg_i[cur_id_q];

	// ==================================================================
	// output registers
	// ==================================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			cur_id_q <= '0;
			irq_q    <= '0;
			nmi_q    <= 1'b0;
		end
		else
		begin
			cur_id_q <= win_id;
			// second stage, fields zero while idle
			if (cur_id_q == '0)
				irq_q <= '0;
			else
			begin
				irq_q.level <= sel_cfg.level;
				irq_q.cause <= sel_cfg.cause;
				irq_q.core  <= sel_cfg.core;
			end
			// nmi bypasses the encoder, gated by enable bit 0
			nmi_q <= nmi_i & ie_i[0];
		end
	end

	assign cur_id_o = cur_id_q;
	assign irq_o    = irq_q;
	assign nmi_o    = nmi_q;

	// a request on the output needs a winner one cycle earlier
	a_irq_has_id: assert property (@(posedge clk) disable iff (rst_i)
		(irq_o != '0) |-> ($past(cur_id_o) != '0));

endmodule

// File: hw/pic_top.sv
`timescale 1ns/1ns

module pic_top import pic_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,
	// axi4-lite register port
	input  axil_addr_t s_awaddr_i,
	input  logic       s_awvalid_i,
	output logic       s_awready_o,
	input  axil_data_t s_wdata_i,
	input  logic [3:0] s_wstrb_i,
	input  logic       s_wvalid_i,
	output logic       s_wready_o,
	output logic [1:0] s_bresp_o,
	output logic       s_bvalid_o,
	input  logic       s_bready_i,
	input  axil_addr_t s_araddr_i,
	input  logic       s_arvalid_i,
	output logic       s_arready_o,
	output axil_data_t s_rdata_o,
	output logic [1:0] s_rresp_o,
	output logic       s_rvalid_o,
	input  logic       s_rready_i,
	// interrupt lines, bit 0 is the nmi
	input  pic_src_t   irq_i,
	// processor side
	output pic_irq_t   irq_o,
	output logic       nmi_o
);

	// register block outputs
	pic_src_t                   ie;
	pic_src_t                   es;
	pic_src_t                   edge_rst;
	pic_src_t                   trig;
	pic_src_cfg_t [NUM_SRC-1:0] src_cfg;
	// sense to encoder
	pic_src_t                   pending;
	// encoder back to the cause register
	pic_id_t                    cur_id;

	// ==================================================================
	// register block
	// ==================================================================

	pic_axil_regs u_regs (
		.clk         (clk),
		.rst_i       (rst_i),
		.s_awaddr_i  (s_awaddr_i),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_wdata_i   (s_wdata_i),
		.s_wstrb_i   (s_wstrb_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_bresp_o   (s_bresp_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_araddr_i  (s_araddr_i),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.cur_id_i    (cur_id),
		.ie_o        (ie),
		.es_o        (es),
		.edge_rst_o  (edge_rst),
		.trig_o      (trig),
		.src_cfg_o   (src_cfg)
	);

	// ==================================================================
	// sense and encode
	// ==================================================================

	pic_source_sense u_sense (
		.clk        (clk),
		.rst_i      (rst_i),
		.irq_i      (irq_i),
		.es_i       (es),
		.edge_rst_i (edge_rst),
		.trig_i     (trig),
		.pending_o  (pending)
	);

	// nmi line goes straight to the encoder's bypass
	pic_prio_encoder u_enc (
		.clk       (clk),
		.rst_i     (rst_i),
		.pending_i (pending),
		.ie_i      (ie),
		.src_cfg_i (src_cfg),
		.nmi_i     (irq_i[0]),
		.cur_id_o  (cur_id),
		.irq_o     (irq_o),
		.nmi_o     (nmi_o)
	);

endmodule

// File: tests/pic_tb.sv
`timescale 1ns/1ns

module pic_tb import pic_pkg::*; ();

	// cycles any single wait may take
	localparam int TIMEOUT = 50;

	logic       clk;
	logic       rst_i;
	axil_addr_t s_awaddr_i;
	logic       s_awvalid_i;
	logic       s_awready_o;
	axil_data_t s_wdata_i;
	logic [3:0] s_wstrb_i;
	logic       s_wvalid_i;
	logic       s_wready_o;
	logic [1:0] s_bresp_o;
	logic       s_bvalid_o;
	logic       s_bready_i;
	axil_addr_t s_araddr_i;
	logic       s_arvalid_i;
	logic       s_arready_o;
	axil_data_t s_rdata_o;
	logic [1:0] s_rresp_o;
	logic       s_rvalid_o;
	logic       s_rready_i;
	pic_src_t   irq_i;
	pic_irq_t   irq_o;
	logic       nmi_o;

	int         errors = 0;
	int         test_base = 0;
	int         pass_cnt = 0;
	int         fail_cnt = 0;
	integer     seed = 32'h512;

	pic_top dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==================================================================
	// bus timing checks
	// ==================================================================

	// write response one cycle after acceptance
	a_b_latency: assert property (@(posedge clk) disable iff (rst_i)
		s_awvalid_i && s_awready_o |=> s_bvalid_o)
	else
	begin
		$display("write response did not arrive one cycle after acceptance");
		errors++;
	end

	// read data one cycle after acceptance
	a_r_latency: assert property (@(posedge clk) disable iff (rst_i)
		s_arvalid_i && s_arready_o |=> s_rvalid_o)
	else
	begin
		$display("read data did not arrive one cycle after acceptance");
		errors++;
	end

	// ==================================================================
	// helpers
	// ==================================================================

	function automatic axil_addr_t src_addr(input int n);
		return REG_SRC_BASE + axil_addr_t'(4 * n);
	endfunction

	// control word as laid out in the register map
	function automatic axil_data_t ctl_word(input pic_cause_t cause, input pic_level_t level,
		input pic_core_t core, input logic ie, input logic es);
		axil_data_t w;
		w = '0;
		w[CTL_CAUSE_LSB +: 8] = cause;
		w[CTL_LEVEL_LSB +: 4] = level;
		w[CTL_CORE_LSB +: 6]  = core;
		w[CTL_IE_BIT]         = ie;
		w[CTL_ES_BIT]         = es;
		return w;
	endfunction

	function automatic pic_irq_t irq_of(input pic_cause_t cause, input pic_level_t level,
		input pic_core_t core);
		pic_irq_t r;
		r.level = level;
		r.cause = cause;
		r.core  = core;
		return r;
	endfunction

	task automatic check_word(input string name, input axil_data_t got, input axil_data_t exp);
		assert (got === exp) else
		begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
		int   t;
		logic ok;
		@(posedge clk);
		s_awaddr_i  <= addr;
		s_wdata_i   <= data;
		s_awvalid_i <= 1'b1;
		s_wvalid_i  <= 1'b1;
		s_bready_i  <= 1'b1;
		t = 0;
		do
		begin
			@(posedge clk);
			ok = s_awready_o & s_wready_o;
			t++;
		end
		while (!ok && t < TIMEOUT);
		s_awvalid_i <= 1'b0;
		s_wvalid_i  <= 1'b0;
		if (!ok)
		begin
			$display("write to offset %h was never accepted", addr);
			errors++;
		end
		else
		begin
			// response is taken on the edge where it is seen
			t = 0;
			do
			begin
				@(posedge clk);
				ok = s_bvalid_o;
				t++;
			end
			while (!ok && t < TIMEOUT);
			if (!ok)
			begin
				$display("write to offset %h got no response", addr);
				errors++;
			end
			else
				check_word("s_bresp_o", s_bresp_o, AXI_RESP_OKAY);
		end
		s_bready_i <= 1'b0;
	endtask

	task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
		int   t;
		logic ok;
		data = 'x;
		@(posedge clk);
		s_araddr_i  <= addr;
		s_arvalid_i <= 1'b1;
		s_rready_i  <= 1'b1;
		t = 0;
		do
		begin
			@(posedge clk);
			ok = s_arready_o;
			t++;
		end
		while (!ok && t < TIMEOUT);
		s_arvalid_i <= 1'b0;
		if (!ok)
		begin
			$display("read of offset %h was never accepted", addr);
			errors++;
		end
		else
		begin
			t = 0;
			do
			begin
				@(posedge clk);
				ok = s_rvalid_o;
				t++;
			end
			while (!ok && t < TIMEOUT);
			if (!ok)
			begin
				$display("read of offset %h returned no data", addr);
				errors++;
			end
			else
			begin
				data = s_rdata_o;
				check_word("s_rresp_o", s_rresp_o, AXI_RESP_OKAY);
			end
		end
		s_rready_i <= 1'b0;
	endtask

	task automatic read_expect(input string name, input axil_addr_t addr, input axil_data_t exp);
		axil_data_t d;
		axil_read(addr, d);
		check_word(name, d, exp);
	endtask

	// poll the processor side until it matches, then check it
	task automatic wait_outputs(input pic_irq_t exp_irq, input logic exp_nmi);
		int t;
		t = 0;
		@(posedge clk);
		while ((irq_o !== exp_irq || nmi_o !== exp_nmi) && t < TIMEOUT)
		begin
			@(posedge clk);
			t++;
		end
		check_word("irq_o", irq_o, exp_irq);
		check_word("nmi_o", nmi_o, exp_nmi);
	endtask

	// outputs must keep their value for a few cycles
	task automatic hold_outputs(input pic_irq_t exp_irq, input logic exp_nmi);
		repeat (4)
		begin
			@(posedge clk);
			check_word("irq_o", irq_o, exp_irq);
			check_word("nmi_o", nmi_o, exp_nmi);
		end
	endtask

	task automatic end_test(input string name);
		if (errors != test_base)
		begin
			fail_cnt++;
			$display("test %s failed", name);
		end
		else
		begin
			pass_cnt++;
			$display("test %s ok", name);
		end
		test_base = errors;
	endtask

	// ==================================================================
	// stimulus
	// ==================================================================

	initial
	begin
		pic_cause_t c5;
		pic_cause_t c9;
		pic_cause_t c12;
		pic_cause_t c20;
		axil_data_t word;

		rst_i       = 1'b1;
		s_awaddr_i  = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i   = '0;
		s_wstrb_i   = 4'hF;
		s_wvalid_i  = 1'b0;
		s_bready_i  = 1'b0;
		s_araddr_i  = '0;
		s_arvalid_i = 1'b0;
		s_rready_i  = 1'b0;
		irq_i       = '0;
		repeat (3) @(posedge clk);
		rst_i <= 1'b0;

		// reset values and control word layout
		check_word("irq_o", irq_o, '0);
		check_word("nmi_o", nmi_o, 1'b0);
		read_expect("ie", REG_IE, '0);
		read_expect("ctl3", src_addr(3), ctl_word('0, 4'd8, '0, 1'b0, 1'b1));
		word = $random(seed);
		axil_write(src_addr(3), word);
		// only cause, level, ie, es and core bits are stored
		read_expect("ctl3", src_addr(3), word & 32'h3F03_0FFF);
		end_test("reset_readback");

		// level source 5
		c5 = pic_cause_t'($random(seed));
		axil_write(src_addr(5), ctl_word(c5, 4'd3, 6'd2, 1'b1, 1'b0));
		@(posedge clk);
		irq_i[5] <= 1'b1;
		wait_outputs(irq_of(c5, 4'd3, 6'd2), 1'b0);
		read_expect("cause", REG_CAUSE, {24'h0, c5});
		irq_i[5] <= 1'b0;
		wait_outputs('0, 1'b0);
		end_test("level_request");

		// 5 beats 9 until it is masked
		c9 = pic_cause_t'($random(seed));
		axil_write(src_addr(9), ctl_word(c9, 4'd5, 6'd4, 1'b1, 1'b0));
		@(posedge clk);
		irq_i[5] <= 1'b1;
		irq_i[9] <= 1'b1;
		wait_outputs(irq_of(c5, 4'd3, 6'd2), 1'b0);
		axil_write(REG_IE_CLR, 32'd5);
		wait_outputs(irq_of(c9, 4'd5, 6'd4), 1'b0);
		axil_write(REG_IE_SET, 32'd5);
		wait_outputs(irq_of(c5, 4'd3, 6'd2), 1'b0);
		irq_i[5] <= 1'b0;
		irq_i[9] <= 1'b0;
		wait_outputs('0, 1'b0);
		end_test("priority");

		// edge source 12 keeps its request after the pulse
		c12 = pic_cause_t'($random(seed));
		axil_write(src_addr(12), ctl_word(c12, 4'd7, 6'd1, 1'b1, 1'b1));
		@(posedge clk);
		irq_i[12] <= 1'b1;
		@(posedge clk);
		irq_i[12] <= 1'b0;
		wait_outputs(irq_of(c12, 4'd7, 6'd1), 1'b0);
		hold_outputs(irq_of(c12, 4'd7, 6'd1), 1'b0);
		axil_write(REG_EDGE_RST, 32'd12);
		wait_outputs('0, 1'b0);
		end_test("edge_latch");

		// software trigger on source 20
		c20 = pic_cause_t'($random(seed));
		axil_write(src_addr(20), ctl_word(c20, 4'd2, 6'd5, 1'b1, 1'b1));
		hold_outputs('0, 1'b0);
		axil_write(REG_TRIG, 32'd20);
		wait_outputs(irq_of(c20, 4'd2, 6'd5), 1'b0);
		axil_write(REG_EDGE_RST, 32'd20);
		wait_outputs('0, 1'b0);
		end_test("trigger");

		// nmi gated by ie bit 0, never seen on irq_o
		@(posedge clk);
		irq_i[0] <= 1'b1;
		hold_outputs('0, 1'b0);
		axil_write(REG_IE_SET, 32'd0);
		wait_outputs('0, 1'b1);
		irq_i[0] <= 1'b0;
		wait_outputs('0, 1'b0);
		irq_i[0] <= 1'b1;
		wait_outputs('0, 1'b1);
		irq_i[0] <= 1'b0;
		wait_outputs('0, 1'b0);
		end_test("nmi");

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: sources.f
hw/pic_pkg.sv
hw/pic_axil_regs.sv
hw/pic_source_sense.sv
hw/pic_prio_encoder.sv
hw/pic_top.sv
tests/pic_tb.sv
